// ==== project.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_execute.sv
rtl/cpu_memory.sv
rtl/cpu_top.sv
verification/tb_clock.sv
verification/tb_cpu.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --assert --timescale 1ns/1ns -j 0
TOP       := tb_cpu
FILELIST  := project.f
OBJ_DIR   := obj_dir

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_cpu.sv ====
/*
 * testbench for the five-stage cpu
 * builds one program, runs it through an instruction-level model to get
 * the expected host writes, loads it while idle and pulses start.
 * the assertions at the bottom compare every host_wr pulse in order
 */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu;

    localparam logic [7:0] OP_ADD  = 8'h10;
    localparam logic [7:0] OP_SUB  = 8'h11;
    localparam logic [7:0] OP_AND  = 8'h12;
    localparam logic [7:0] OP_OR   = 8'h13;
    localparam logic [7:0] OP_ADDI = 8'h18;
    localparam logic [7:0] OP_LD   = 8'h80;
    localparam logic [7:0] OP_ST   = 8'h83;
    localparam logic [7:0] OP_BEQ  = 8'h31;
    localparam logic [7:0] OP_BNEQ = 8'h33;
    localparam logic [7:0] OP_JMP  = 8'h3D;
    localparam int MAX_WRITES   = 64;
    localparam int DRAIN_CYCLES = 40;

    logic                             clk;
    logic                             rst_n;
    logic                             load_en;
    logic [$clog2(`CPU_IM_WORDS)-1:0] load_addr;
    logic [`CPU_XLEN-1:0]             load_data;
    logic                             start;
    logic                             running;
    logic                             host_wr;
    logic [`CPU_AW-1:0]               host_addr;
    logic [`CPU_XLEN-1:0]             host_data;

    logic [31:0] prog [`CPU_IM_WORDS];
    int          prog_len;
    logic [31:0] rng;
    logic [15:0] exp_addr [MAX_WRITES];      // expected host writes, in order
    logic [31:0] exp_data [MAX_WRITES];
    int          exp_cnt;
    int          exp_idx;                    // next write the dut owes us
    int          model_steps;
    int          watchdog_cycles;
    logic        started;
    logic        drain_done;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    cpu_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .running   (running),
        .host_wr   (host_wr),
        .host_addr (host_addr),
        .host_data (host_data)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] encode_r(input logic [7:0] op, input int rd, rs, rt);
        return {op, 4'(rd), 4'(rs), 4'(rt), 12'h000};
    endfunction

    function automatic logic [31:0] encode_i(input logic [7:0] op, input int rd, rs,
                                             input logic [15:0] imm);
        return {op, 4'(rd), 4'(rs), imm};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "check failed");
    endtask

    ////////////////////////////////////////
    // program
    ////////////////////////////////////////

    task automatic build_program();
        int loop_at;
        int fix_at;
        for (int k = 0; k < `CPU_IM_WORDS; k++)
            prog[k] = 32'h0;                 // unused words are nops
        prog_len = 0;
        // dependent chain on random immediates
        rng = next_random(rng);
        emit(encode_i(OP_ADDI, 1, 0, rng[15:0]));
        rng = next_random(rng);
        emit(encode_i(OP_ADDI, 2, 1, rng[15:0]));
        emit(encode_r(OP_ADD, 3, 1, 2));
        emit(encode_r(OP_SUB, 4, 3, 1));
        emit(encode_r(OP_AND, 5, 4, 3));
        emit(encode_r(OP_OR, 6, 5, 2));
        emit(encode_i(OP_ST, 6, 0, 16'h9000));
        emit(encode_i(OP_ST, 4, 0, 16'h9004));
        // independent, back to back
        for (int k = 0; k < 4; k++) begin
            rng = next_random(rng);
            emit(encode_i(OP_ADDI, 7 + k, 0, rng[15:0]));
        end
        for (int k = 0; k < 4; k++)
            emit(encode_i(OP_ST, 7 + k, 0, 16'(16'h9010 + k * 4)));
        // data memory round trip
        emit(encode_i(OP_ST, 6, 0, 16'h0040));
        emit(encode_i(OP_LD, 12, 0, 16'h0040));
        emit(encode_i(OP_ST, 12, 0, 16'h9020));
        emit(encode_i(OP_ADDI, 13, 0, 16'h0020));
        emit(encode_i(OP_ST, 4, 13, 16'h0008));
        emit(encode_i(OP_LD, 14, 13, 16'h0008));
        emit(encode_i(OP_ST, 14, 0, 16'h9024));
        // jmp over a store that must never show
        emit(encode_i(OP_JMP, 0, 0, 16'((prog_len + 2) * 4)));
        emit(encode_i(OP_ST, 0, 0, 16'h90F0));
        // countdown 3, 2, 1
        emit(encode_i(OP_ADDI, 15, 0, 16'd3));
        emit(encode_i(OP_ADDI, 2, 0, 16'd1));
        loop_at = prog_len;
        emit(encode_i(OP_ST, 15, 0, 16'h9030));
        emit(encode_r(OP_SUB, 15, 15, 2));
        emit(encode_i(OP_BNEQ, 0, 0, 16'(loop_at * 4)));
        // zero still set, beq skips
        fix_at = prog_len;
        emit(32'h0);
        emit(encode_i(OP_ST, 7, 0, 16'h9040));
        prog[fix_at] = encode_i(OP_BEQ, 0, 0, 16'(prog_len * 4));
        emit(encode_i(OP_ADDI, 11, 0, 16'd5));
        fix_at = prog_len;                   // not taken, store kept
        emit(32'h0);
        emit(encode_i(OP_ST, 11, 0, 16'h9044));
        prog[fix_at] = encode_i(OP_BEQ, 0, 0, 16'(prog_len * 4));
        emit(encode_r(OP_SUB, 12, 11, 11));
        fix_at = prog_len;
        emit(32'h0);
        emit(encode_i(OP_ST, 8, 0, 16'h9048));
        prog[fix_at] = encode_i(OP_BNEQ, 0, 0, 16'(prog_len * 4));
        emit(encode_i(OP_JMP, 0, 0, 16'(prog_len * 4)));   // park here
    endtask

    ////////////////////////////////////////
    // instruction-level model
    ////////////////////////////////////////

    task automatic run_model();
        logic [31:0] r [16];
        logic [31:0] dm [64];
        logic [31:0] w, y;
        logic [15:0] pc, imm, addr;
        logic [7:0]  op;
        logic [3:0]  rd, rs, rt;
        logic        zf;
        logic        halted;
        for (int k = 0; k < 16; k++)
            r[k] = 32'h0;
        for (int k = 0; k < 64; k++)
            dm[k] = 32'h0;
        pc = 16'h0;
        zf = 1'b0;
        halted = 1'b0;
        exp_cnt = 0;
        model_steps = 0;
        while (!halted) begin
            w    = prog[pc[7:2]];
            op   = w[31:24];
            rd   = w[23:20];
            rs   = w[19:16];
            rt   = w[15:12];
            imm  = w[15:0];
            addr = 16'(r[rs] + {16'h0000, imm});
            pc   = pc + 16'd4;
            model_steps++;
            case (op)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI: begin
                    case (op)
                        OP_ADD:  y = r[rs] + r[rt];
                        OP_SUB:  y = r[rs] - r[rt];
                        OP_AND:  y = r[rs] & r[rt];
                        OP_OR:   y = r[rs] | r[rt];
                        default: y = r[rs] + {16'h0000, imm};
                    endcase
                    r[rd] = y;
                    zf    = (y == 32'h0);
                end
                OP_LD: r[rd] = dm[addr[7:2]];
                OP_ST: begin
                    if (addr >= `CPU_HOST_BASE) begin
                        exp_addr[exp_cnt] = addr;
                        exp_data[exp_cnt] = r[rd];
                        exp_cnt++;
                    end else begin
                        dm[addr[7:2]] = r[rd];
                    end
                end
                OP_BEQ:  if (zf) pc = imm;
                OP_BNEQ: if (!zf) pc = imm;
                OP_JMP: begin
                    halted = (imm == pc - 16'd4);    // jump to itself ends it
                    pc     = imm;
                end
                default: ;
            endcase
            if (model_steps > 4000) begin
                $display("model never reached the final jump, program is broken");
                $display("tests failed");
                $fatal(1, "model runaway");
            end
        end
    endtask

    task automatic load_program();
        for (int k = 0; k < `CPU_IM_WORDS; k++) begin
            load_en   = 1'b1;
            load_addr = 6'(k);
            load_data = prog[k];
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    ////////////////////////////////////////
    // stimulus and watchdog
    ////////////////////////////////////////

    initial begin
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        started    = 1'b0;
        drain_done = 1'b0;
        rng        = 32'd49;
        watchdog_cycles = 0;
        build_program();
        run_model();
        watchdog_cycles = prog_len * 12 + 200 + `CPU_IM_WORDS + 20;   // load and reset too
        wait (rst_n);
        @(negedge clk);
        load_program();
        start   = 1'b1;
        started = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait (exp_idx == exp_cnt);
        repeat (DRAIN_CYCLES) @(negedge clk);   // room for stray writes
        drain_done = 1'b1;
        repeat (2) @(negedge clk);
        $display("all tests passed");
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timed out after %0d cycles with %0d of %0d host writes seen",
                 watchdog_cycles, exp_idx, exp_cnt);
        $display("tests failed");
        $fatal(1, "watchdog");
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            exp_idx <= 0;
        else if (host_wr)
            exp_idx <= exp_idx + 1;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!running && !host_wr))
        else report_failure("running or host_wr high before start");

    // writes past the end of the queue are left to the drain check
    a_host_order: assert property (@(posedge clk) disable iff (!rst_n)
        (host_wr && exp_idx < exp_cnt) |-> (host_addr == exp_addr[exp_idx]
                                             && host_data == exp_data[exp_idx]))
        else report_failure($sformatf("host write %0d is %h <= %h, expected %h <= %h",
                            exp_idx, host_addr, host_data, exp_addr[exp_idx],
                            exp_data[exp_idx]));

    a_drained: assert property (@(posedge clk) disable iff (!rst_n)
        drain_done |-> exp_idx == exp_cnt)
        else report_failure($sformatf("%0d host writes seen after drain, expected %0d",
                            exp_idx, exp_cnt));

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
/*
 * clock and reset for the cpu testbench
 * 40 ns clock, reset held low for the first 10 cycles
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;                        // released mid-cycle
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
/*
 * five-stage cpu, top level
 * load the program while idle with load_en, then pulse start.
 * stores into the host window come out as single-cycle host_wr pulses
 */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module cpu_top (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             load_en,
    input  wire logic [$clog2(`CPU_IM_WORDS)-1:0] load_addr,
    input  wire logic [`CPU_XLEN-1:0]             load_data,
    input  wire logic                             start,
    output logic                                  running,
    output logic                                  host_wr,
    output logic [`CPU_AW-1:0]                    host_addr,
    output logic [`CPU_XLEN-1:0]                  host_data
);
    import cpu_pkg::*;

    if_id_t             if_id;
    id_ex_t             id_ex;
    ex_mem_t            ex_mem;
    mem_wb_t            mem_wb;
    logic               redirect;
    logic [`CPU_AW-1:0] target;

    ////////////////////////////////////////
    // stages
    ////////////////////////////////////////

    cpu_fetch u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .redirect  (redirect),
        .target    (target),
        .id_ex     (id_ex),                  // hazard view
        .ex_mem    (ex_mem),
        .running   (running),
        .if_id     (if_id)
    );

    cpu_decode u_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .if_id  (if_id),
        .mem_wb (mem_wb),                    // rf write port
        .id_ex  (id_ex)
    );

    cpu_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .redirect (redirect),
        .target   (target)
    );

    cpu_memory u_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .host_wr   (host_wr),
        .host_addr (host_addr),
        .host_data (host_data)
    );

endmodule

`default_nettype wire

// ==== rtl/cpu_memory.sv ====
/*
 * memory stage
 * stores below the host window go to data memory, stores inside it
 * show on the host port for the one cycle the store sits here. loads
 * read asynchronously; the mem/wb register feeds the register file
 */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module cpu_memory (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  cpu_pkg::ex_mem_t      ex_mem,
    output cpu_pkg::mem_wb_t      mem_wb,
    output logic                  host_wr,
    output logic [`CPU_AW-1:0]    host_addr,
    output logic [`CPU_XLEN-1:0]  host_data
);
    import cpu_pkg::*;

    localparam int DW = $clog2(`CPU_DM_WORDS);

    logic [`CPU_XLEN-1:0] dmem [`CPU_DM_WORDS];
    logic [DW-1:0]        dm_idx;
    logic                 in_host;
    logic [`CPU_XLEN-1:0] rd_data;

    assign dm_idx  = ex_mem.result[DW+1:2];          // word index
    assign in_host = ex_mem.result[`CPU_AW-1:0] >= `CPU_HOST_BASE;
    assign rd_data = dmem[dm_idx];

    // host window
    assign host_wr   = ex_mem.store && in_host;
    assign host_addr = ex_mem.result[`CPU_AW-1:0];
    assign host_data = ex_mem.st_data;

    always_ff @(posedge clk) begin
        if (ex_mem.store && !in_host)
            dmem[dm_idx] <= ex_mem.st_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.rd   <= ex_mem.rd;
            mem_wb.we   <= ex_mem.we;
            mem_wb.data <= ex_mem.load ? rd_data : ex_mem.result;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_execute.sv ====
/*
 * execute stage
 * alu, zero flag, branch resolution and the ex/mem
 * register. a taken branch drives redirect and target to fetch for
 * the one cycle it sits here
 */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module cpu_execute (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  cpu_pkg::id_ex_t     id_ex,
    output cpu_pkg::ex_mem_t    ex_mem,
    output logic                redirect,
    output logic [`CPU_AW-1:0]  target
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] opb, alu_y;
    logic                 set_flags;
    logic                 zf;

    assign opb = id_ex.imm_sel ? id_ex.imm : id_ex.b;

    always_comb begin
        case (id_ex.op)
            OP_ADD, OP_ADDI, OP_LD, OP_ST: alu_y = id_ex.a + opb;   // ld/st give the address
            OP_SUB:                        alu_y = id_ex.a - opb;
            OP_AND:                        alu_y = id_ex.a & opb;
            OP_OR:                         alu_y = id_ex.a | opb;
            default:                       alu_y = '0;
        endcase
    end

    ////////////////////////////////////////
    // flags and branches
    ////////////////////////////////////////

    assign set_flags = id_ex.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zf <= 1'b0;
        end else if (set_flags) begin
            zf <= (alu_y == '0);
        end
    end

    // flags already hold the older alu result here
    assign redirect = (id_ex.op == OP_BEQ && zf)
                    || (id_ex.op == OP_BNEQ && !zf)
                    || (id_ex.op == OP_JMP);
    assign target   = id_ex.imm[`CPU_AW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.op      <= id_ex.op;
            ex_mem.rd      <= id_ex.rd;
            ex_mem.we      <= id_ex.we;
            ex_mem.load    <= (id_ex.op == OP_LD);
            ex_mem.store   <= (id_ex.op == OP_ST);
            ex_mem.result  <= alu_y;
            ex_mem.st_data <= id_ex.st_data;
        end
    end

    // fetch holds a nop behind every branch
    a_redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect);

endmodule

`default_nettype wire

// ==== rtl/cpu_decode.sv ====
/*
 * decode stage
 * register file with a combinational read and a write from writeback,
 * opcode decode into control bits and the id/ex register. opcodes
 * outside the supported set leave as a nop
 */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module cpu_decode (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  cpu_pkg::if_id_t    if_id,
    input  cpu_pkg::mem_wb_t   mem_wb,
    output cpu_pkg::id_ex_t    id_ex
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] regs [`CPU_REGS];
    instr_t               ins;
    id_ex_t               nxt;

    assign ins = if_id.instr;

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `CPU_REGS; k++)
                regs[k] <= '0;
        end else if (mem_wb.we) begin
            regs[mem_wb.rd] <= mem_wb.data;
        end
    end

    ////////////////////////////////////////
    // control decode
    ////////////////////////////////////////

    always_comb begin
        nxt = '0;                                    // nop unless recognised
        case (ins.r.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                nxt.op = ins.r.op;
                nxt.rd = ins.r.rd;
                nxt.we = 1'b1;
                nxt.a  = regs[ins.r.rs];
                nxt.b  = regs[ins.r.rt];
            end
            OP_ADDI, OP_LD: begin
                nxt.op      = ins.i.op;
                nxt.rd      = ins.i.rd;
                nxt.we      = 1'b1;
                nxt.a       = regs[ins.i.rs];
                nxt.imm     = {{(`CPU_XLEN-16){1'b0}}, ins.i.imm};
                nxt.imm_sel = 1'b1;
            end
            OP_ST: begin
                nxt.op      = ins.i.op;
                nxt.a       = regs[ins.i.rs];        // base
                nxt.st_data = regs[ins.i.rd];        // rd is the data source
                nxt.imm     = {{(`CPU_XLEN-16){1'b0}}, ins.i.imm};
                nxt.imm_sel = 1'b1;
            end
            OP_BEQ, OP_BNEQ, OP_JMP: begin
                nxt.op  = ins.i.op;
                nxt.imm = {{(`CPU_XLEN-16){1'b0}}, ins.i.imm};   // byte target
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            id_ex <= '0;
        else
            id_ex <= nxt;
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_fetch.sv ====
/*
 * fetch stage
 * holds the idle/run state, the pc and the instruction memory. in idle
 * the memory is written through the load strobe; a start pulse begins
 * fetching from address 0. hazards and pending branches inject nops
 */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module cpu_fetch (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            load_en,
    input  wire logic [$clog2(`CPU_IM_WORDS)-1:0] load_addr,
    input  wire logic [`CPU_XLEN-1:0]            load_data,
    input  wire logic                            start,
    input  wire logic                            redirect,
    input  wire logic [`CPU_AW-1:0]              target,
    input  cpu_pkg::id_ex_t                      id_ex,
    input  cpu_pkg::ex_mem_t                     ex_mem,
    output logic                                 running,
    output cpu_pkg::if_id_t                      if_id
);
    import cpu_pkg::*;

    localparam int IW = $clog2(`CPU_IM_WORDS);

    logic [`CPU_XLEN-1:0] imem [`CPU_IM_WORDS];
    logic [`CPU_AW-1:0]   pc;
    instr_t               fetched;
    logic [3:0]           src1, src2;
    logic                 use1, use2;
    logic                 raw_stall, br_stall, stall;

    function automatic logic writes_reg(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LD};
    endfunction

    function automatic logic is_branch(opcode_t op);
        return op inside {OP_BEQ, OP_BNEQ, OP_JMP};
    endfunction

    assign fetched = imem[pc[IW+1:2]];

    ////////////////////////////////////////
    // hazard detect
    ////////////////////////////////////////

    assign src1 = fetched.r.rs;
    assign src2 = (fetched.r.op == OP_ST) ? fetched.r.rd : fetched.r.rt;   // st reads rd
    assign use1 = fetched.r.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LD, OP_ST};
    assign use2 = fetched.r.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ST};

    function automatic logic hit(logic we, logic [3:0] rd, logic [3:0] s1, logic [3:0] s2,
                                 logic u1, logic u2);
        return we && ((u1 && rd == s1) || (u2 && rd == s2));
    endfunction

    // mem/wb needs no check, rf write lands before decode
    assign raw_stall = hit(writes_reg(if_id.instr.r.op), if_id.instr.r.rd, src1, src2, use1, use2)
                     | hit(id_ex.we, id_ex.rd, src1, src2, use1, use2)
                     | hit(ex_mem.we, ex_mem.rd, src1, src2, use1, use2);
    assign br_stall  = is_branch(if_id.instr.r.op) | is_branch(id_ex.op);
    assign stall     = raw_stall | br_stall;

    ////////////////////////////////////////
    // pc, run state, if/id
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            pc      <= '0;
            if_id   <= '0;
        end else begin
            if (start)
                running <= 1'b1;
            if (redirect)
                pc <= target;                        // taken branch, end of execute
            else if (running && !stall)
                pc <= pc + `CPU_AW'(4);
            if_id.instr <= (running && !stall) ? fetched : '0;   // nop on stall or idle
        end
    end

    // loader port, idle only
    always_ff @(posedge clk) begin
        if (load_en && !running)
            imem[load_addr] <= load_data;
    end

    a_no_load_running: assert property (@(posedge clk) disable iff (!rst_n)
        running |-> !load_en);

    a_no_redirect_idle: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> running);

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
/*
 * types shared by the pipeline stages
 * opcode encoding, the two decode views of an instruction word and the
 * four stage registers. stages import it inside the module body
 */
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h10,
        OP_SUB  = 8'h11,
        OP_AND  = 8'h12,
        OP_OR   = 8'h13,
        OP_ADDI = 8'h18,
        OP_LD   = 8'h80,
        OP_ST   = 8'h83,
        OP_BEQ  = 8'h31,
        OP_BNEQ = 8'h33,
        OP_JMP  = 8'h3D
    } opcode_t;

    // register-register view
    typedef struct packed {
        opcode_t     op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [11:0] unused;
    } instr_r_t;

    // immediate view, also branch target
    typedef struct packed {
        opcode_t     op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    ////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////

    typedef struct packed {
        instr_t instr;                       // all zero is a nop
    } if_id_t;

    typedef struct packed {
        opcode_t               op;
        logic [3:0]            rd;
        logic                  we;
        logic [`CPU_XLEN-1:0]  a;            // rs
        logic [`CPU_XLEN-1:0]  b;            // rt
        logic [`CPU_XLEN-1:0]  st_data;      // rd, stores only
        logic [`CPU_XLEN-1:0]  imm;          // zero extended
        logic                  imm_sel;
    } id_ex_t;

    typedef struct packed {
        opcode_t               op;
        logic [3:0]            rd;
        logic                  we;
        logic                  load;
        logic                  store;
        logic [`CPU_XLEN-1:0]  result;       // alu out or address
        logic [`CPU_XLEN-1:0]  st_data;
    } ex_mem_t;

    typedef struct packed {
        logic [3:0]            rd;
        logic                  we;
        logic [`CPU_XLEN-1:0]  data;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_cfg.svh ====
/*
 * sizes and address map of the five-stage cpu
 * included by the package and by every stage that sizes a memory,
 * a port or an address compare
 */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath
`define CPU_XLEN 32              // data word width
`define CPU_AW 16                // byte address width, pc and data
`define CPU_REGS 16              // register file entries

// memories, word deep
`define CPU_IM_WORDS 64
`define CPU_DM_WORDS 64

// stores at or above this byte address go out on the host port
`define CPU_HOST_BASE 16'h9000

`endif
